//--- verilog/icache_config.svh
/*
 * Geometry, refill bus widths and the uncacheable region of the instruction cache.
 * Include this header in every file that needs one of these constants.
 */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Cache geometry
`define ICACHE_SETS        16
`define ICACHE_LINE_WIDTH  128

// Refill read channel
`define AXI_DATA_WIDTH     32
`define AXI_ADDR_WIDTH     32
`define AXI_ID_WIDTH       2
`define ICACHE_RD_ID       1
`define LINE_BEATS         (`ICACHE_LINE_WIDTH / `AXI_DATA_WIDTH)

// Fetches with this address bit set bypass the cache
`define NC_ADDR_BIT        31

`endif

//--- verilog/icache_pkg.sv
/*
 * Types shared by the cache core and the bus wrapper.
 * Referenced with scoped names, never imported.
 */
`include "icache_config.svh"

package icache_pkg;

  // Fetch address, seen either as a raw byte address or split for the lookup
  typedef union packed {
    logic [`AXI_ADDR_WIDTH-1:0] raw;
    struct packed {
      logic [`AXI_ADDR_WIDTH - $clog2(`ICACHE_SETS) - $clog2(`LINE_BEATS)
             - $clog2(`AXI_DATA_WIDTH / 8) - 1:0] tag;
      logic [$clog2(`ICACHE_SETS)-1:0]           index;
      logic [$clog2(`LINE_BEATS)-1:0]            word_off;
      logic [$clog2(`AXI_DATA_WIDTH / 8)-1:0]    byte_off;
    } fields;
  } fetch_addr_u;

  // Kind of data returned by the bus wrapper
  typedef enum logic {
    FILL   = 1'b0,
    SINGLE = 1'b1
  } rtrn_type_e;

endpackage

//--- verilog/icache_core.sv
/*
 * Direct-mapped instruction cache with tag, valid and data arrays.
 * Serves one fetch at a time; misses and bypassed fetches go to the memory
 * side as a single request and block until the return arrives.
 */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_core (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          en_i,
  input  logic                          fetch_req_i,
  input  icache_pkg::fetch_addr_u       fetch_addr_i,
  output logic                          fetch_ready_o,
  output logic                          fetch_valid_o,
  output logic [31:0]                   fetch_data_o,
  output logic                          miss_o,
  output logic                          busy_o,
  output logic                          mem_req_o,
  output logic [31:0]                   mem_addr_o,
  output logic                          mem_nc_o,
  input  logic                          rtrn_valid_i,
  input  icache_pkg::rtrn_type_e        rtrn_type_i,
  input  logic [`ICACHE_LINE_WIDTH-1:0] rtrn_data_i
);

  localparam int unsigned IdxW = $clog2(`ICACHE_SETS);
  localparam int unsigned OffW = $clog2(`ICACHE_LINE_WIDTH / 8);
  localparam int unsigned TagW = 32 - IdxW - OffW;

  // Controller states
  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StMiss  = 2'd1;
  localparam logic [1:0] StFlush = 2'd2;

  logic [1:0]                    state_d, state_q;
  logic [IdxW-1:0]               flush_cnt_q;
  logic                          flush_pend_q;
  logic [`ICACHE_SETS-1:0]       valid_q;
  logic [TagW-1:0]               tag_q  [`ICACHE_SETS];
  logic [`ICACHE_LINE_WIDTH-1:0] data_q [`ICACHE_SETS];

  icache_pkg::fetch_addr_u       addr_q;
  icache_pkg::fetch_addr_u       req_addr;

  logic                          fetch_accept;
  logic                          fetch_bypass;
  logic                          fetch_hit;
  logic                          fetch_to_mem;
  logic [`ICACHE_LINE_WIDTH-1:0] hit_line;
  logic [31:0]                   hit_word;
  logic [31:0]                   rtrn_word;
  logic                          refill_done;
  logic                          rtrn_fill;

  logic                          fetch_valid_q;
  logic                          miss_q;
  logic                          mem_req_q;
  logic                          mem_nc_q;
  logic [31:0]                   fetch_data_q;
  logic [31:0]                   mem_addr_q;

  // A flush request wins over a fetch in the same cycle
  assign fetch_ready_o = (state_q == StIdle) & ~flush_i;
  assign fetch_accept  = fetch_req_i & fetch_ready_o;

  // Lookup on the incoming address
  assign fetch_bypass = ~en_i | fetch_addr_i.raw[`NC_ADDR_BIT];
  assign fetch_hit    = ~fetch_bypass & valid_q[fetch_addr_i.fields.index] &
                        (tag_q[fetch_addr_i.fields.index] == fetch_addr_i.fields.tag);
  assign fetch_to_mem = fetch_accept & ~fetch_hit;
  assign hit_line     = data_q[fetch_addr_i.fields.index];
  assign hit_word     = hit_line[fetch_addr_i.fields.word_off * 32 +: 32];

  // Returned data, selected with the address of the pending fetch
  assign refill_done = (state_q == StMiss) & rtrn_valid_i;
  assign rtrn_fill   = refill_done & (rtrn_type_i == icache_pkg::FILL);
  assign rtrn_word   = rtrn_data_i[addr_q.fields.word_off * 32 +: 32];

  // Line address for a refill, word address for a bypass
  always_comb begin
    req_addr                 = fetch_addr_i;
    req_addr.fields.byte_off = '0;
    if (!fetch_bypass) begin
      req_addr.fields.word_off = '0;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (flush_i) begin
          state_d = StFlush;
        end else if (fetch_to_mem) begin
          state_d = StMiss;
        end
      end
      StMiss: begin
        // A flush seen during the miss runs right after the return
        if (rtrn_valid_i) begin
          state_d = (flush_i | flush_pend_q) ? StFlush : StIdle;
        end
      end
      StFlush: begin
        if (flush_cnt_q == IdxW'(`ICACHE_SETS - 1)) begin
          state_d = StIdle;
        end
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= StIdle;
      flush_cnt_q   <= '0;
      flush_pend_q  <= 1'b0;
      valid_q       <= '0;
      fetch_valid_q <= 1'b0;
      miss_q        <= 1'b0;
      mem_req_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      fetch_valid_q <= (fetch_accept & fetch_hit) | refill_done;
      miss_q        <= fetch_to_mem & ~fetch_bypass;
      mem_req_q     <= fetch_to_mem;

      if (state_d == StFlush) begin
        flush_pend_q <= 1'b0;
      end else if (flush_i && state_q == StMiss) begin
        flush_pend_q <= 1'b1;
      end

      // One line invalidated per cycle
      if (state_q == StFlush) begin
        flush_cnt_q          <= flush_cnt_q + IdxW'(1);
        valid_q[flush_cnt_q] <= 1'b0;
      end else begin
        flush_cnt_q <= '0;
      end

      if (rtrn_fill) begin
        valid_q[addr_q.fields.index] <= 1'b1;
      end
    end
  end

  // Arrays and request payload
  always_ff @(posedge clk_i) begin
    if (fetch_accept) begin
      addr_q     <= fetch_addr_i;
      mem_addr_q <= req_addr.raw;
      mem_nc_q   <= fetch_bypass;
    end

    if (fetch_accept && fetch_hit) begin
      fetch_data_q <= hit_word;
    end else if (refill_done) begin
      // Uncached words always come back at offset 0
      fetch_data_q <= rtrn_fill ? rtrn_word : rtrn_data_i[31:0];
    end

    if (rtrn_fill) begin
      tag_q[addr_q.fields.index]  <= addr_q.fields.tag;
      data_q[addr_q.fields.index] <= rtrn_data_i;
    end
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_data_o  = fetch_data_q;
  assign miss_o        = miss_q;
  assign busy_o        = (state_q == StFlush);
  assign mem_req_o     = mem_req_q;
  assign mem_addr_o    = mem_addr_q;
  assign mem_nc_o      = mem_nc_q;

endmodule

//--- verilog/axi_rd_shim.sv
/*
 * Read-channel master for the cache refill path.
 * Registers one request, holds the address channel until accepted and
 * forwards the matching read beats until the last one.
 */
`timescale 1ns/1ps
`include "icache_config.svh"

module axi_rd_shim (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Request and beat interface towards the wrapper
  input  logic                       rd_req_i,
  output logic                       rd_gnt_o,
  input  logic [`AXI_ADDR_WIDTH-1:0] rd_addr_i,
  input  logic [7:0]                 rd_len_i,
  input  logic [`AXI_ID_WIDTH-1:0]   rd_id_i,
  output logic                       rd_valid_o,
  output logic [`AXI_DATA_WIDTH-1:0] rd_data_o,
  output logic                       rd_last_o,

  // Read address channel
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output logic [`AXI_ADDR_WIDTH-1:0] ar_addr_o,
  output logic [7:0]                 ar_len_o,
  output logic [`AXI_ID_WIDTH-1:0]   ar_id_o,

  // Read data channel, never stalled
  input  logic                       r_valid_i,
  input  logic [`AXI_DATA_WIDTH-1:0] r_data_i,
  input  logic                       r_last_i,
  input  logic [`AXI_ID_WIDTH-1:0]   r_id_i
);

  logic                       ar_valid_q;
  logic [`AXI_ADDR_WIDTH-1:0] ar_addr_q;
  logic [7:0]                 ar_len_q;
  logic [`AXI_ID_WIDTH-1:0]   ar_id_q;
  logic                       rd_busy_q;

  logic                       ar_hs;
  logic                       launch;
  logic                       outstanding;
  logic                       beat_ok;

  assign ar_hs  = ar_valid_q & ar_ready_i;

  // New request only when the channel is free and nothing is in flight
  assign launch = rd_req_i & ~ar_valid_q & ~rd_busy_q;

  // Beats may arrive as early as the handshake cycle
  assign outstanding = rd_busy_q | ar_hs;
  assign beat_ok     = r_valid_i & outstanding & (r_id_i == ar_id_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_valid_q <= 1'b0;
      rd_busy_q  <= 1'b0;
    end else begin
      if (launch) begin
        ar_valid_q <= 1'b1;
      end else if (ar_hs) begin
        ar_valid_q <= 1'b0;
      end

      if (beat_ok && r_last_i) begin
        rd_busy_q <= 1'b0;
      end else if (ar_hs) begin
        rd_busy_q <= 1'b1;
      end
    end
  end

  // Address payload stays put until the handshake
  always_ff @(posedge clk_i) begin
    if (launch) begin
      ar_addr_q <= rd_addr_i;
      ar_len_q  <= rd_len_i;
      ar_id_q   <= rd_id_i;
    end
  end

  assign rd_gnt_o   = ar_hs;
  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = ar_addr_q;
  assign ar_len_o   = ar_len_q;
  assign ar_id_o    = ar_id_q;

  assign rd_valid_o = beat_ok;
  assign rd_data_o  = r_data_i;
  assign rd_last_o  = r_last_i;

endmodule

//--- verilog/icache_axi_wrapper.sv
/*
 * Top level of the instruction cache with its refill read channel.
 * Turns core requests into bursts and assembles returning beats into a line.
 */
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_axi_wrapper (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Fetch side
  input  logic                       flush_i,
  input  logic                       en_i,
  input  logic                       fetch_req_i,
  input  icache_pkg::fetch_addr_u    fetch_addr_i,
  output logic                       fetch_ready_o,
  output logic                       fetch_valid_o,
  output logic [31:0]                fetch_data_o,
  output logic                       miss_o,
  output logic                       busy_o,

  // Refill read channel
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  output logic [`AXI_ADDR_WIDTH-1:0] ar_addr_o,
  output logic [7:0]                 ar_len_o,
  output logic [`AXI_ID_WIDTH-1:0]   ar_id_o,
  input  logic                       r_valid_i,
  input  logic [`AXI_DATA_WIDTH-1:0] r_data_i,
  input  logic                       r_last_i,
  input  logic [`AXI_ID_WIDTH-1:0]   r_id_i
);

  logic                          mem_req;
  logic [31:0]                   mem_addr;
  logic                          mem_nc;
  logic                          rtrn_valid;
  icache_pkg::rtrn_type_e        rtrn_type;
  logic [`ICACHE_LINE_WIDTH-1:0] rtrn_data;

  logic                          rd_req;
  logic                          rd_gnt;
  logic [`AXI_ADDR_WIDTH-1:0]    rd_addr;
  logic [7:0]                    rd_len;
  logic [`AXI_ID_WIDTH-1:0]      rd_id;
  logic                          rd_valid;
  logic [`AXI_DATA_WIDTH-1:0]    rd_data;
  logic                          rd_last;

  logic                          req_valid_d, req_valid_q;
  logic [`AXI_ADDR_WIDTH-1:0]    req_addr_d, req_addr_q;
  logic                          req_nc_d, req_nc_q;
  logic                          first_d, first_q;
  logic [`LINE_BEATS-1:0][`AXI_DATA_WIDTH-1:0] rd_shift_d, rd_shift_q;

  // Hold the request until the address channel grants it
  assign req_valid_d = ~rd_gnt & (mem_req | req_valid_q);
  assign req_addr_d  = mem_req ? mem_addr : req_addr_q;
  assign req_nc_d    = mem_req ? mem_nc : req_nc_q;

  assign rd_req  = mem_req | req_valid_q;
  assign rd_addr = req_addr_d;

  // Whole line on a miss, one beat on a bypass
  assign rd_len  = req_nc_d ? 8'd0 : 8'(`LINE_BEATS - 1);
  assign rd_id   = `AXI_ID_WIDTH'(`ICACHE_RD_ID);

  // Line goes back together with the last beat
  assign rtrn_valid = rd_valid & rd_last;
  assign rtrn_data  = rd_shift_d;
  assign rtrn_type  = req_nc_q ? icache_pkg::SINGLE : icache_pkg::FILL;

  icache_core u_core (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .flush_i       ( flush_i       ),
    .en_i          ( en_i          ),
    .fetch_req_i   ( fetch_req_i   ),
    .fetch_addr_i  ( fetch_addr_i  ),
    .fetch_ready_o ( fetch_ready_o ),
    .fetch_valid_o ( fetch_valid_o ),
    .fetch_data_o  ( fetch_data_o  ),
    .miss_o        ( miss_o        ),
    .busy_o        ( busy_o        ),
    .mem_req_o     ( mem_req       ),
    .mem_addr_o    ( mem_addr      ),
    .mem_nc_o      ( mem_nc        ),
    .rtrn_valid_i  ( rtrn_valid    ),
    .rtrn_type_i   ( rtrn_type     ),
    .rtrn_data_i   ( rtrn_data     )
  );

  axi_rd_shim u_shim (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .rd_req_i   ( rd_req     ),
    .rd_gnt_o   ( rd_gnt     ),
    .rd_addr_i  ( rd_addr    ),
    .rd_len_i   ( rd_len     ),
    .rd_id_i    ( rd_id      ),
    .rd_valid_o ( rd_valid   ),
    .rd_data_o  ( rd_data    ),
    .rd_last_o  ( rd_last    ),
    .ar_valid_o ( ar_valid_o ),
    .ar_ready_i ( ar_ready_i ),
    .ar_addr_o  ( ar_addr_o  ),
    .ar_len_o   ( ar_len_o   ),
    .ar_id_o    ( ar_id_o    ),
    .r_valid_i  ( r_valid_i  ),
    .r_data_i   ( r_data_i   ),
    .r_last_i   ( r_last_i   ),
    .r_id_i     ( r_id_i     )
  );

  // Beats enter the line from the top and move down one word each
  always_comb begin
    first_d    = first_q;
    rd_shift_d = rd_shift_q;

    if (rd_valid) begin
      first_d    = rd_last;
      rd_shift_d = {rd_data, rd_shift_q[`LINE_BEATS-1:1]};

      // First beat also lands at word 0, which is where a lone beat belongs
      if (first_q) begin
        rd_shift_d[0] = rd_data;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
      first_q     <= 1'b1;
    end else begin
      req_valid_q <= req_valid_d;
      first_q     <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_addr_q <= req_addr_d;
    req_nc_q   <= req_nc_d;
    rd_shift_q <= rd_shift_d;
  end

endmodule

//--- tests/axi_mem_slave.sv
/*
 * Read-only memory slave for the cache refill channel.
 * Stalls each address handshake by 0 to 3 random cycles, then returns the
 * burst one beat per cycle from a 1 KiB word array that the testbench fills.
 */
`timescale 1ns/1ps
`include "icache_config.svh"

module axi_mem_slave (
  input  logic                       clk_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0] ar_addr_i,
  input  logic [7:0]                 ar_len_i,
  input  logic [`AXI_ID_WIDTH-1:0]   ar_id_i,
  output logic                       r_valid_o,
  output logic [`AXI_DATA_WIDTH-1:0] r_data_o,
  output logic                       r_last_o,
  output logic [`AXI_ID_WIDTH-1:0]   r_id_o
);

  // Word array, indexed by address bits 9:2
  logic [31:0] mem [256];

  initial begin
    int                       stall;
    logic [7:0]               word_idx;
    logic [7:0]               len;
    logic [`AXI_ID_WIDTH-1:0] id;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_last_o   = 1'b0;
    r_id_o     = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (ar_valid_i) begin
        stall = $urandom_range(3, 0);
        repeat (stall) begin
          @(posedge clk_i);
          #1;
        end
        // Handshake completes on the next rising edge
        ar_ready_o = 1'b1;
        word_idx   = ar_addr_i[9:2];
        len        = ar_len_i;
        id         = ar_id_i;
        @(posedge clk_i);
        #1;
        ar_ready_o = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
          r_valid_o = 1'b1;
          r_data_o  = mem[word_idx];
          r_last_o  = (beat == len);
          r_id_o    = id;
          word_idx++;
          @(posedge clk_i);
          #1;
        end
        r_valid_o = 1'b0;
        r_last_o  = 1'b0;
      end
    end
  end

endmodule

//--- tests/tb_icache.sv
/*
 * Testbench for the instruction cache top level.
 * Random fetches, flushes and enable changes are checked against a model
 * of the valid and tag arrays and against the slave memory contents.
 */
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_icache;

  localparam int NumFetches    = 400;
  localparam int TimeoutCycles = NumFetches * 40;
  localparam int LineBytes     = `ICACHE_LINE_WIDTH / 8;

  logic                       clk_i, rst_ni, flush_i, en_i, fetch_req_i;
  logic [31:0]                fetch_addr_i, fetch_data_o;
  logic                       fetch_ready_o, fetch_valid_o, miss_o, busy_o;
  logic                       ar_valid_o, ar_ready_i, r_valid_i, r_last_i;
  logic [`AXI_ADDR_WIDTH-1:0] ar_addr_o;
  logic [7:0]                 ar_len_o;
  logic [`AXI_ID_WIDTH-1:0]   ar_id_o, r_id_i;
  logic [`AXI_DATA_WIDTH-1:0] r_data_i;

  // Model of the valid and tag arrays
  logic                       model_valid [`ICACHE_SETS];
  logic [31:0]                model_tag   [`ICACHE_SETS];
  int                         cycle_cnt = 0;
  logic                       en_lvl = 1'b1;
  logic                       held_valid = 1'b0;
  logic [63:0]                held_ar;

  icache_axi_wrapper u_dut (.*);

  axi_mem_slave u_mem (
    .clk_i      ( clk_i      ),
    .ar_valid_i ( ar_valid_o ),
    .ar_ready_o ( ar_ready_i ),
    .ar_addr_i  ( ar_addr_o  ),
    .ar_len_i   ( ar_len_o   ),
    .ar_id_i    ( ar_id_o    ),
    .r_valid_o  ( r_valid_i  ),
    .r_data_o   ( r_data_i   ),
    .r_last_o   ( r_last_i   ),
    .r_id_o     ( r_id_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic require(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("%s", msg);
      abort_run();
    end
  endtask

  task automatic check_idle();
    compare_value("idle ar_valid", 0, ar_valid_o);
    compare_value("idle fetch_valid", 0, fetch_valid_o);
    compare_value("idle miss", 0, miss_o);
    compare_value("idle busy", 0, busy_o);
    compare_value("idle fetch_ready", 1, fetch_ready_o);
  endtask

  // busy_o covers exactly one cycle per set, then the model forgets every line
  task automatic run_flush();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    for (int i = 0; i < `ICACHE_SETS; i++) begin
      @(negedge clk_i);
      compare_value("flush busy", 1, busy_o);
      compare_value("flush fetch_ready", 0, fetch_ready_o);
    end
    @(negedge clk_i);
    compare_value("flush end busy", 0, busy_o);
    for (int i = 0; i < `ICACHE_SETS; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  task automatic do_fetch(input logic [31:0] addr, input logic en);
    logic        bypass;
    logic        hit;
    logic        done;
    int          idx;
    int          lat;
    int          ar_cnt;
    int          miss_cnt;
    logic [31:0] tag;
    logic [31:0] exp_ar_addr;
    bypass      = !en || addr[`NC_ADDR_BIT];
    idx         = (addr / LineBytes) % `ICACHE_SETS;
    tag         = addr / (LineBytes * `ICACHE_SETS);
    hit         = !bypass && model_valid[idx] && (model_tag[idx] == tag);
    exp_ar_addr = bypass ? (addr & ~32'd3) : (addr & ~32'(LineBytes - 1));
    @(posedge clk_i);
    #1;
    require(fetch_ready_o, "Cache not ready when a fetch was due");
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    en_i         = en;
    @(posedge clk_i);
    #1;
    fetch_req_i = 1'b0;
    lat      = 0;
    ar_cnt   = 0;
    miss_cnt = 0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      lat++;
      if (miss_o) begin
        miss_cnt++;
      end
      if (ar_valid_o && ar_ready_i) begin
        ar_cnt++;
        compare_value("ar_addr", exp_ar_addr, ar_addr_o);
        compare_value("ar_len", bypass ? 0 : `LINE_BEATS - 1, ar_len_o);
        compare_value("ar_id", `ICACHE_RD_ID, ar_id_o);
      end
      done = fetch_valid_o;
    end
    compare_value("fetch data", u_mem.mem[addr[9:2]], fetch_data_o);
    compare_value("miss pulses", (!hit && !bypass) ? 1 : 0, miss_cnt);
    compare_value("address handshakes", hit ? 0 : 1, ar_cnt);
    if (hit) begin
      compare_value("hit latency", 1, lat);
      // A request sent on a hit would raise the address channel now
      @(negedge clk_i);
      compare_value("hit ar_valid", 0, ar_valid_o);
    end else if (!bypass) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles with fetches still pending", cycle_cnt);
      abort_run();
    end
  end

  // A stalled address must stay valid and unchanged until the handshake
  always @(negedge clk_i) begin
    if (rst_ni && held_valid) begin
      require(ar_valid_o, "ar_valid_o dropped before the address was accepted");
      compare_value("stalled ar payload", held_ar, {ar_addr_o, ar_len_o, ar_id_o});
    end
    held_valid = ar_valid_o && !ar_ready_i;
    held_ar    = {ar_addr_o, ar_len_o, ar_id_o};
  end

  initial begin
    logic [31:0] addr;
    void'($urandom(32'h7913));
    for (int i = 0; i < 256; i++) begin
      u_mem.mem[i] = $urandom();
    end
    for (int i = 0; i < `ICACHE_SETS; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    en_i         = 1'b1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    repeat (3) begin
      @(posedge clk_i);
      #1;
      check_idle();
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle();

    // Small window for frequent hits, one address in eight uncacheable
    for (int n = 0; n < NumFetches; n++) begin
      if ($urandom_range(19, 0) == 0) begin
        run_flush();
      end
      if ($urandom_range(15, 0) == 0) begin
        en_lvl = ~en_lvl;
      end
      addr = {$urandom_range(7, 0) == 0, 22'd0, 7'($urandom()), 2'b00};
      do_fetch(addr, en_lvl);
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_core.sv
verilog/axi_rd_shim.sv
verilog/icache_axi_wrapper.sv
tests/axi_mem_slave.sv
tests/tb_icache.sv
